// ==== Makefile ====
VERILATOR  ?= verilator
FLAGS      := --binary --timing -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
TOP        := io_sys_tb
RTL_TOP    := io_sys
FILELIST   := io_sys.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/io_sys_tb.sv ====
// ------------------------------------------------
// I/O subsystem testbench
// directed tests of decode, board I/O, ms timer,
// process timers and system control over the bus
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module io_sys_tb;

  import io_pkg::*;

  localparam int clk_period      = 100;   // ns
  localparam int watchdog_cycles = 2000;  // tests take about 300 cycles

  logic        clk;
  logic        rst;
  logic        bus_stb;
  logic        bus_we;
  logic [23:2] bus_addr;
  word_t       bus_dout;
  word_t       bus_din;
  logic        bus_ack;
  logic [17:0] led;
  logic [17:0] swi;
  logic [3:0]  btn_n;
  logic        sys_rst;

  int seed         = 95;
  int checks       = 0;
  int errors       = 0;
  int tests_run    = 0;
  int tests_failed = 0;

  // 10 kHz setting gives a 10 cycle millisecond
  io_sys #(.clock_freq(10_000), .num_timers(8)) DUT (.*);

  always #(clk_period / 2) clk = ~clk;

  // ------------------------------------------------
  // compare tasks and test bookkeeping
  // ------------------------------------------------

  task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_cause(input string name, input rst_cause_e exp, input rst_cause_e act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Mismatch %s: expected %s (%0d), actual %s (%0d)", name,
               exp.name(), exp, act.name(), act);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  // ------------------------------------------------
  // bus and board drivers
  // ------------------------------------------------

  function automatic logic [23:2] io_addr(input logic [5:0] slot);
    return {io_page, slot};
  endfunction

  // op 31:30, timer index 27:24, argument 15:0
  function automatic word_t ptmr_cmd(input ptmr_op_e op, input logic [3:0] idx,
                                     input logic [15:0] arg);
    return {op, 2'b00, idx, 8'h00, arg};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // one strobe cycle, ack and data sampled mid cycle
  task automatic bus_access(input logic we, input logic [23:2] addr, input word_t wdata,
                            output word_t rdata, output logic ack);
    @(posedge clk);
    #1;
    bus_stb  = 1'b1;
    bus_we   = we;
    bus_addr = addr;
    bus_dout = wdata;
    @(negedge clk);
    ack   = bus_ack;
    rdata = bus_din;
    @(posedge clk);
    #1;
    bus_stb  = 1'b0;
    bus_we   = 1'b0;
    bus_addr = '0;
    bus_dout = '0;
  endtask

  task automatic bus_write(input logic [23:2] addr, input word_t data, output logic ack);
    word_t unused_rd;
    bus_access(1'b1, addr, data, unused_rd, ack);
  endtask

  task automatic bus_read(input logic [23:2] addr, output word_t data, output logic ack);
    bus_access(1'b0, addr, '0, data, ack);
  endtask

  task automatic drive_board(input logic [17:0] swi_val, input logic [3:0] btn_val);
    @(posedge clk);
    #1;
    swi   = swi_val;
    btn_n = btn_val;
  endtask

  // cycles until sys_rst rises, then its high time
  task automatic count_pulse(input int max_wait, output int lag, output int len);
    lag = 0;
    len = 0;
    @(negedge clk);
    while (!sys_rst && lag < max_wait) begin
      @(negedge clk);
      lag++;
    end
    while (sys_rst && len < 16) begin
      len++;
      @(negedge clk);
    end
  endtask

  // ------------------------------------------------
  // tests
  // ------------------------------------------------

  task automatic test_decode();
    int         e0;
    word_t      d;
    logic       ack;
    logic [5:0] slots [4];
    e0    = errors;
    slots = '{slot_tmr, slot_lsb, slot_ptmr, slot_scr};
    // nonzero switch and ms count data, so a leak shows on unmapped reads
    drive_board(18'h2_A5C3, 4'hF);
    wait_cycles(12);  // past the first ms tick
    bus_read(io_addr(6'd10), d, ack);  // unmapped slot
    check_bit("decode unmapped ack", 1'b0, ack);
    check_word("decode unmapped data", '0, d);
    bus_read({16'h7FFF, slot_lsb}, d, ack);  // lsb slot, wrong page
    check_bit("decode off page ack", 1'b0, ack);
    check_word("decode off page data", '0, d);
    bus_write(io_addr(6'd10), 32'h0003_FFFF, ack);
    check_bit("decode unmapped write ack", 1'b0, ack);
    bus_write({16'h7FFF, slot_lsb}, 32'h0003_FFFF, ack);
    bus_write({16'h7FFF, slot_scr}, 32'h0000_0001, ack);  // reset request off page
    check_word("decode led unchanged", 32'd0, {14'd0, led});
    check_bit("decode no reset pulse", 1'b0, sys_rst);
    bus_read(io_addr(slot_scr), d, ack);
    check_cause("decode cause unchanged", cause_none, rst_cause_e'(d[1:0]));
    foreach (slots[i]) begin
      bus_read(io_addr(slots[i]), d, ack);
      check_bit("decode mapped ack", 1'b1, ack);
    end
    end_test("decode", e0);
  endtask

  task automatic test_board_io();
    int          e0;
    int          n;
    word_t       d;
    word_t       rnd;
    logic        ack;
    logic [17:0] led_val;
    e0 = errors;
    for (n = 0; n < 3; n++) begin
      rnd = $random(seed);
      drive_board(rnd[17:0], {rnd[21:19], 1'b1});  // button 0 released, no reset
      wait_cycles(2);
      bus_read(io_addr(slot_lsb), d, ack);  // 3 edges after the change
      check_word("board_io readback", {10'd0, ~btn_n, swi}, d);
    end
    rnd     = $random(seed);
    led_val = rnd[17:0];
    bus_write(io_addr(slot_lsb), {14'd0, led_val}, ack);
    check_bit("board_io led write ack", 1'b1, ack);
    check_word("board_io led", {14'd0, led_val}, {14'd0, led});
    end_test("board_io", e0);
  endtask

  task automatic test_ms_timer();
    int    e0;
    word_t t0;
    word_t t1;
    logic  ack;
    e0 = errors;
    bus_read(io_addr(slot_tmr), t0, ack);
    wait_cycles(48);  // next strobe 50 cycles after the first
    bus_read(io_addr(slot_tmr), t1, ack);
    check_word("ms_timer 5 ms delta", t0 + 32'd5, t1);
    end_test("ms_timer", e0);
  endtask

  task automatic test_proc_timers();
    int    e0;
    int    n;
    word_t d;
    logic  ack;
    e0 = errors;
    bus_write(io_addr(slot_ptmr), ptmr_cmd(op_set_period, 4'd2, 16'd3), ack);
    check_bit("proc_timers write ack", 1'b1, ack);
    bus_write(io_addr(slot_ptmr), ptmr_cmd(op_set_period, 4'd5, 16'd6), ack);
    wait_cycles(33);  // read about 3.5 ms after the writes
    bus_read(io_addr(slot_ptmr), d, ack);
    check_word("proc_timers 3.5 ms", 32'h0000_0004, d);
    wait_cycles(29);  // about 6.5 ms
    bus_read(io_addr(slot_ptmr), d, ack);
    check_word("proc_timers 6.5 ms", 32'h0000_0024, d);
    bus_write(io_addr(slot_ptmr), ptmr_cmd(op_clear_ready, 4'd0, 16'h0004), ack);
    bus_read(io_addr(slot_ptmr), d, ack);
    check_word("proc_timers clear bit 2", 32'h0000_0020, d);
    bus_write(io_addr(slot_ptmr), ptmr_cmd(op_disable, 4'd5, 16'd0), ack);
    bus_write(io_addr(slot_ptmr), ptmr_cmd(op_clear_ready, 4'd0, 16'h0020), ack);
    // timer 5 would have expired again inside this window
    for (n = 0; n < 7; n++) begin
      wait_cycles(8);
      bus_read(io_addr(slot_ptmr), d, ack);
      check_bit("proc_timers disabled bit 5", 1'b0, d[5]);
    end
    end_test("proc_timers", e0);
  endtask

  task automatic test_sys_ctrl();
    int    e0;
    int    lag;
    int    len;
    word_t d;
    logic  ack;
    e0 = errors;
    check_bit("sys_ctrl idle", 1'b0, sys_rst);
    bus_write(io_addr(slot_scr), 32'h0000_0001, ack);
    count_pulse(10, lag, len);
    if (len == 0) begin
      errors++;
      $display("sys_ctrl: no reset pulse after the software request");
    end else begin
      check_word("sys_ctrl sw pulse start", 32'd0, word_t'(lag));
      check_word("sys_ctrl sw pulse length", word_t'(rst_pulse_len), word_t'(len));
    end
    bus_read(io_addr(slot_scr), d, ack);
    check_cause("sys_ctrl sw cause", cause_sw, rst_cause_e'(d[1:0]));
    check_bit("sys_ctrl active flag clear", 1'b0, d[2]);
    drive_board(swi, 4'b1110);  // press button 0
    count_pulse(10, lag, len);
    if (len == 0) begin
      errors++;
      $display("sys_ctrl: no reset pulse after pressing button 0");
    end else begin
      check_word("sys_ctrl btn pulse length", word_t'(rst_pulse_len), word_t'(len));
    end
    drive_board(swi, 4'b1111);
    bus_read(io_addr(slot_scr), d, ack);
    check_cause("sys_ctrl btn cause", cause_btn, rst_cause_e'(d[1:0]));
    bus_write(io_addr(slot_scr), 32'h0000_0001, ack);
    bus_read(io_addr(slot_scr), d, ack);  // second cycle of the pulse
    check_bit("sys_ctrl active flag set", 1'b1, d[2]);
    end_test("sys_ctrl", e0);
  endtask

  // ------------------------------------------------
  // main sequence and watchdog
  // ------------------------------------------------

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    bus_stb  = 1'b0;
    bus_we   = 1'b0;
    bus_addr = '0;
    bus_dout = '0;
    swi      = '0;
    btn_n    = 4'hF;  // all released
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    test_decode();
    test_board_io();
    test_ms_timer();
    test_proc_timers();
    test_sys_ctrl();
    $display("tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("watchdog: run not finished after %0d cycles", watchdog_cycles);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hdl/board_io.sv ====
// ------------------------------------------------
// board I/O
// LED register, plus synchronized switches and
// active low buttons for readback
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module board_io (
  input  wire                clk,
  input  wire                rst,
  input  wire                stb,
  input  wire                we,
  input  wire io_pkg::word_t data_in,
  output io_pkg::word_t      data_out,
  output logic [17:0]        led,
  input  wire  [17:0]        swi,
  input  wire  [3:0]         btn_n,     // active low
  output logic               btn_rst    // synced button 0
);

  logic [21:0] raw;     // buttons inverted, switches
  logic [21:0] sync_1;  // first stage, may be metastable
  logic [21:0] sync_2;  // second stage, safe to use

  // ------------------------------------------------
  // LED register
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      led <= '0;  // all off
    end else if (stb && we) begin
      led <= data_in[17:0];
    end
  end

  // ------------------------------------------------
  // two flop synchronizer, buttons and switches
  // ------------------------------------------------

  assign raw = {~btn_n, swi};  // pressed reads as 1

  always_ff @(posedge clk) begin
    if (rst) begin
      sync_1 <= '0;
      sync_2 <= '0;
    end else begin
      sync_1 <= raw;
      sync_2 <= sync_1;
    end
  end

  // buttons 21:18, switches 17:0
  assign data_out = {10'd0, sync_2};
  assign btn_rst  = sync_2[18];  // button 0

endmodule

`default_nettype wire

// ==== hdl/io_decode.sv ====
// ------------------------------------------------
// I/O decoder
// decodes the I/O page into device strobes and
// returns the selected device's data and the ack
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module io_decode (
  input  wire              bus_stb,
  input  wire [23:2]       bus_addr,   // word address
  output logic             tmr_stb,
  output logic             lsb_stb,
  output logic             ptmr_stb,
  output logic             scr_stb,
  input  wire io_pkg::word_t tmr_dout,
  input  wire io_pkg::word_t lsb_dout,
  input  wire io_pkg::word_t ptmr_dout,
  input  wire io_pkg::word_t scr_dout,
  output io_pkg::word_t    bus_din,
  output logic             bus_ack
);

  import io_pkg::*;

  logic       io_hit;  // access inside the I/O page
  logic [5:0] slot;    // word index in the page

  // ------------------------------------------------
  // address decode
  // ------------------------------------------------

  assign io_hit = bus_stb && (bus_addr[23:8] == io_page);
  assign slot   = bus_addr[7:2];

  assign tmr_stb  = io_hit && (slot == slot_tmr);
  assign lsb_stb  = io_hit && (slot == slot_lsb);
  assign ptmr_stb = io_hit && (slot == slot_ptmr);
  assign scr_stb  = io_hit && (slot == slot_scr);

  // ------------------------------------------------
  // read data and acknowledge return
  // ------------------------------------------------

  // at most one strobe is up, slots are distinct
  always_comb begin
    if (tmr_stb) begin
      bus_din = tmr_dout;
    end else if (lsb_stb) begin
      bus_din = lsb_dout;
    end else if (ptmr_stb) begin
      bus_din = ptmr_dout;
    end else if (scr_stb) begin
      bus_din = scr_dout;
    end else begin
      bus_din = '0;  // unmapped reads give zero
    end
  end

  // every mapped device answers in the strobe cycle
  assign bus_ack = tmr_stb | lsb_stb | ptmr_stb | scr_stb;

endmodule

`default_nettype wire

// ==== hdl/io_pkg.sv ====
// ------------------------------------------------
// io package
// shared definitions for the I/O subsystem: bus
// word, I/O page address map, process timer
// commands and system reset causes
// ------------------------------------------------

`default_nettype none

package io_pkg;

  // bus data word
  typedef logic [31:0] word_t;

  // ------------------------------------------------
  // address map, 16 MB space, word addressed
  // ------------------------------------------------

  // upper address bits 23:8 of the I/O page @ 0xFFFF00
  localparam logic [15:0] io_page = 16'hFFFF;

  // word slots within the page, bits 7:2
  localparam logic [5:0] slot_tmr  = 6'd48;  // -64, ms timer
  localparam logic [5:0] slot_lsb  = 6'd49;  // -60, leds/switches/buttons
  localparam logic [5:0] slot_ptmr = 6'd31;  // -132, process timers
  localparam logic [5:0] slot_scr  = 6'd47;  // -68, system control

  // ------------------------------------------------
  // process timer commands, write data bits 31:30
  // ------------------------------------------------

  typedef enum logic [1:0] {
    op_set_period  = 2'd0,  // load period, enable
    op_disable     = 2'd1,  // stop the timer
    op_clear_ready = 2'd2   // clear ready bits by mask
  } ptmr_op_e;              // code 3 unused

  // system reset causes
  typedef enum logic [1:0] {
    cause_none = 2'd0,
    cause_sw   = 2'd1,  // software request via scr
    cause_btn  = 2'd2   // reset button
  } rst_cause_e;

  // reset pulse length in clock cycles
  localparam logic [2:0] rst_pulse_len = 3'd4;

endpackage

`default_nettype wire

// ==== hdl/io_sys.sv ====
// ------------------------------------------------
// I/O subsystem top level
// memory mapped devices on the processor bus:
// ms timer, process timers, board I/O, sys control
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module io_sys #(
  parameter int clock_freq = 50_000_000,  // Hz
  parameter int num_timers = 8            // process timers
) (
  input  wire                clk,
  input  wire                rst,
  // processor bus
  input  wire                bus_stb,
  input  wire                bus_we,
  input  wire  [23:2]        bus_addr,
  input  wire io_pkg::word_t bus_dout,   // write data
  output io_pkg::word_t      bus_din,    // read data
  output logic               bus_ack,
  // board
  output logic [17:0]        led,
  input  wire  [17:0]        swi,
  input  wire  [3:0]         btn_n,
  output logic               sys_rst
);

  import io_pkg::*;

  // device strobes
  logic  tmr_stb;
  logic  lsb_stb;
  logic  ptmr_stb;
  logic  scr_stb;
  // device read data
  word_t tmr_dout;
  word_t lsb_dout;
  word_t ptmr_dout;
  word_t scr_dout;
  // side band
  logic  tmr_tick;  // ms tick to process timers
  logic  btn_rst;   // reset button to sys ctrl

  // ------------------------------------------------
  // decoder and devices
  // ------------------------------------------------

  io_decode decode_0 (
    .bus_stb(bus_stb),
    .bus_addr(bus_addr),
    .tmr_stb(tmr_stb),
    .lsb_stb(lsb_stb),
    .ptmr_stb(ptmr_stb),
    .scr_stb(scr_stb),
    .tmr_dout(tmr_dout),
    .lsb_dout(lsb_dout),
    .ptmr_dout(ptmr_dout),
    .scr_dout(scr_dout),
    .bus_din(bus_din),
    .bus_ack(bus_ack)
  );

  // read only, so tmr_stb only selects its data
  ms_timer #(.clock_freq(clock_freq)) tmr_0 (
    .clk(clk),
    .rst(rst),
    .data_out(tmr_dout),
    .tick(tmr_tick)
  );

  proc_timers #(.num_timers(num_timers)) ptmr_0 (
    .clk(clk),
    .rst(rst),
    .stb(ptmr_stb),
    .we(bus_we),
    .tick(tmr_tick),
    .data_in(bus_dout),
    .data_out(ptmr_dout)
  );

  board_io lsb_0 (
    .clk(clk),
    .rst(rst),
    .stb(lsb_stb),
    .we(bus_we),
    .data_in(bus_dout),
    .data_out(lsb_dout),
    .led(led),
    .swi(swi),
    .btn_n(btn_n),
    .btn_rst(btn_rst)
  );

  sys_ctrl scr_0 (
    .clk(clk),
    .rst(rst),
    .stb(scr_stb),
    .we(bus_we),
    .data_in(bus_dout),
    .data_out(scr_dout),
    .btn_rst(btn_rst),
    .sys_rst(sys_rst)
  );

endmodule

`default_nettype wire

// ==== hdl/ms_timer.sv ====
// ------------------------------------------------
// millisecond timer
// divides the clock down to a 1 ms tick and keeps
// a free running millisecond count for readback
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module ms_timer #(
  parameter int clock_freq = 50_000_000  // Hz
) (
  input  wire           clk,
  input  wire           rst,
  output io_pkg::word_t data_out,  // ms count, always visible
  output logic          tick       // one cycle per ms
);

  import io_pkg::*;

  localparam int cycles_per_ms = clock_freq / 1000;
  localparam int cnt_w = (cycles_per_ms > 1) ? $clog2(cycles_per_ms) : 1;

  logic [cnt_w-1:0] div_cnt;  // divider, counts down
  word_t            ms_cnt;   // elapsed milliseconds

  // divider wraps every cycles_per_ms clocks
  always_ff @(posedge clk) begin
    if (rst) begin
      div_cnt <= cnt_w'(cycles_per_ms - 1);
      tick    <= 1'b0;
    end else if (div_cnt == '0) begin
      div_cnt <= cnt_w'(cycles_per_ms - 1);  // reload
      tick    <= 1'b1;
    end else begin
      div_cnt <= div_cnt - 1'b1;
      tick    <= 1'b0;
    end
  end

  // count follows the tick by one cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      ms_cnt <= '0;
    end else if (tick) begin
      ms_cnt <= ms_cnt + 32'd1;
    end
  end

  assign data_out = ms_cnt;

endmodule

`default_nettype wire

// ==== hdl/proc_timers.sv ====
// ------------------------------------------------
// process timers
// bank of periodic timers clocked by the ms tick,
// each raising a ready bit once per period
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module proc_timers #(
  parameter int num_timers = 8  // 1 to 16
) (
  input  wire                clk,
  input  wire                rst,
  input  wire                stb,
  input  wire                we,
  input  wire                tick,     // ms tick
  input  wire io_pkg::word_t data_in,
  output io_pkg::word_t      data_out  // ready bits
);

  import io_pkg::*;

  logic      wr;   // write strobe
  ptmr_op_e  op;   // command, bits 31:30
  logic [3:0] idx; // timer index, bits 27:24

  logic [15:0] period [num_timers];  // reload value
  logic [15:0] cnt [num_timers];     // ticks left in period

  logic [num_timers-1:0] en;      // timer running
  logic [num_timers-1:0] ready;   // period elapsed, sticky
  logic [num_timers-1:0] load;    // set period on timer i
  logic [num_timers-1:0] stop;    // disable timer i
  logic [num_timers-1:0] expire;  // last tick of the period

  assign wr  = stb & we;
  assign op  = ptmr_op_e'(data_in[31:30]);
  assign idx = data_in[27:24];

  // ------------------------------------------------
  // per timer command decode and expiry
  // ------------------------------------------------

  always_comb begin
    for (int i = 0; i < num_timers; i++) begin
      load[i]   = wr && (op == op_set_period) && (idx == 4'(i));
      stop[i]   = wr && (op == op_disable) && (idx == 4'(i));
      expire[i] = tick && en[i] && (cnt[i] == 16'd1) && !load[i];  // load wins
    end
  end

  // period and counter, gated by en so no reset needed
  always_ff @(posedge clk) begin
    for (int i = 0; i < num_timers; i++) begin
      if (load[i]) begin
        period[i] <= data_in[15:0];
        cnt[i]    <= data_in[15:0];
      end else if (tick && en[i]) begin
        if (cnt[i] == 16'd1) begin
          cnt[i] <= period[i];  // start next period
        end else begin
          cnt[i] <= cnt[i] - 16'd1;
        end
      end
    end
  end

  // ------------------------------------------------
  // enables and ready bits
  // ------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      en    <= '0;
      ready <= '0;
    end else begin
      if (wr && (op == op_clear_ready)) begin
        ready <= ready & ~data_in[num_timers-1:0];  // mask clear
      end
      for (int i = 0; i < num_timers; i++) begin
        if (load[i]) begin
          en[i] <= (data_in[15:0] != 16'd0);  // zero period stays off
        end else if (stop[i]) begin
          en[i] <= 1'b0;
        end
        if (expire[i]) begin
          ready[i] <= 1'b1;  // set beats a same cycle clear
        end
      end
    end
  end

  assign data_out = {{(32 - num_timers){1'b0}}, ready};

endmodule

`default_nettype wire

// ==== hdl/sys_ctrl.sv ====
// ------------------------------------------------
// system control register
// software or button reset request, fixed length
// reset pulse and a record of the last cause
// ------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module sys_ctrl (
  input  wire                clk,
  input  wire                rst,
  input  wire                stb,
  input  wire                we,
  input  wire io_pkg::word_t data_in,
  output io_pkg::word_t      data_out,  // active flag, cause
  input  wire                btn_rst,   // synced reset button
  output logic               sys_rst
);

  import io_pkg::*;

  logic       sw_req;     // reset request write
  logic       btn_q;      // button, one cycle late
  logic       btn_req;    // button rising edge
  logic [2:0] pulse_cnt;  // cycles of pulse left
  rst_cause_e cause;      // last reset cause

  assign sw_req  = stb && we && data_in[0];
  assign btn_req = btn_rst && !btn_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      btn_q     <= 1'b0;
      pulse_cnt <= '0;
      cause     <= cause_none;
    end else begin
      btn_q <= btn_rst;
      if (pulse_cnt != '0) begin
        pulse_cnt <= pulse_cnt - 3'd1;  // requests ignored here
      end else if (sw_req || btn_req) begin
        pulse_cnt <= rst_pulse_len;
        cause     <= sw_req ? cause_sw : cause_btn;  // sw first
      end
    end
  end

  // high for rst_pulse_len cycles after the request
  assign sys_rst = (pulse_cnt != '0);

  assign data_out = {29'd0, sys_rst, cause};

endmodule

`default_nettype wire

// ==== io_sys.f ====
hdl/io_pkg.sv
hdl/io_decode.sv
hdl/ms_timer.sv
hdl/proc_timers.sv
hdl/board_io.sv
hdl/sys_ctrl.sv
hdl/io_sys.sv
dv/io_sys_tb.sv
